// ==== design/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define DATA_W   32
`define REG_N    32
`define IMM_W    16

`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_ORI   6'h0D
`define OP_LW    6'h23
`define OP_SW    6'h2B
`define OP_PERF  6'h1C // Custom rdperf.

`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_SLT   6'h2A

`endif

// ==== design/mips_pkg.sv ====
`include "mips_config.svh"

package mips_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field and word types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`DATA_W-1:0]         word_t;     // Data or instruction word.
    typedef logic [$clog2(`REG_N)-1:0]  reg_addr_t; // Register number.
    typedef logic [`IMM_W-1:0]          imm_t;      // Raw immediate field.
    typedef logic [5:0]                 opcode_t;
    typedef logic [5:0]                 funct_t;

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////////////////////////

    // Zero is AND so an all-zero bubble decodes to a legal operation.
    typedef enum logic [2:0] {
        ALU_AND = 3'd0,
        ALU_OR  = 3'd1,
        ALU_ADD = 3'd2,
        ALU_SUB = 3'd6,
        ALU_SLT = 3'd7
    } alu_ctrl_t;

endpackage

// ==== design/id_ex_if.sv ====
`timescale 1ns/1ns

interface id_ex_if import mips_pkg::*; (
    input logic clk
);
    // Controls.
    logic      readperf;
    logic      memtoreg;
    logic      memwrite;
    logic      alusrc;
    logic      regdst;
    logic      regwrite;
    alu_ctrl_t alucontrol;

    // Data.
    word_t     pcplus4;
    word_t     srca;
    word_t     srcc;      // Cycle count.
    word_t     writedata; // Second register operand.
    word_t     signimm;
    word_t     instr;

    modport producer (
        input  clk,
        output readperf, memtoreg, memwrite, alusrc, regdst, regwrite, alucontrol,
        output pcplus4, srca, srcc, writedata, signimm, instr
    );

    modport consumer (
        input  clk,
        input  readperf, memtoreg, memwrite, alusrc, regdst, regwrite, alucontrol,
        input  pcplus4, srca, srcc, writedata, signimm, instr
    );

endinterface

// ==== design/regfile.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    output word_t     rd1,
    output word_t     rd2,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd
);

    word_t regs [1:`REG_N-1]; // No storage for register 0.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write data bypasses the array.
    always_comb begin
        if (ra1 == '0) begin
            rd1 = '0;
        end else if (we && (wa == ra1)) begin
            rd1 = wd;
        end else begin
            rd1 = regs[ra1];
        end
    end

    always_comb begin
        if (ra2 == '0) begin
            rd2 = '0;
        end else if (we && (wa == ra2)) begin
            rd2 = wd;
        end else begin
            rd2 = regs[ra2];
        end
    end

    a_zero_reg: assert property (@(posedge clk) disable iff (reset)
        ((ra1 == '0) |-> (rd1 == '0)) and ((ra2 == '0) |-> (rd2 == '0)))
        else $error("register 0 read back nonzero");

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module decode_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     instr,
    input  word_t     pcplus4,
    output reg_addr_t ra1,
    output reg_addr_t ra2,
    input  word_t     rd1,
    input  word_t     rd2,
    id_ex_if.producer id
);

    opcode_t opcode;
    funct_t  funct;
    imm_t    imm;
    word_t   cycle_cnt;

    assign opcode = instr[31:26];
    assign ra1    = instr[25:21]; // rs.
    assign ra2    = instr[20:16]; // rt.
    assign imm    = instr[15:0];
    assign funct  = instr[5:0];

    //////////////////////////////////////////////////////////////////////
    // Control decoder
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        id.readperf   = 1'b0;
        id.memtoreg   = 1'b0;
        id.memwrite   = 1'b0;
        id.alusrc     = 1'b0;
        id.regdst     = 1'b0;
        id.regwrite   = 1'b0;
        id.alucontrol = ALU_AND;
        case (opcode)
            `OP_RTYPE: begin
                id.regdst   = 1'b1;
                id.regwrite = 1'b1;
                case (funct)
                    `FN_ADD: id.alucontrol = ALU_ADD;
                    `FN_SUB: id.alucontrol = ALU_SUB;
                    `FN_AND: id.alucontrol = ALU_AND;
                    `FN_OR:  id.alucontrol = ALU_OR;
                    `FN_SLT: id.alucontrol = ALU_SLT;
                    default: begin
                        id.regdst   = 1'b0; // Unknown funct writes nothing.
                        id.regwrite = 1'b0;
                    end
                endcase
            end
            `OP_ADDI: begin
                id.alusrc     = 1'b1;
                id.regwrite   = 1'b1;
                id.alucontrol = ALU_ADD;
            end
            `OP_ORI: begin
                id.alusrc     = 1'b1;
                id.regwrite   = 1'b1;
                id.alucontrol = ALU_OR;
            end
            `OP_LW: begin
                id.alusrc     = 1'b1;
                id.memtoreg   = 1'b1;
                id.regwrite   = 1'b1;
                id.alucontrol = ALU_ADD;
            end
            `OP_SW: begin
                id.alusrc     = 1'b1;
                id.memwrite   = 1'b1;
                id.alucontrol = ALU_ADD;
            end
            `OP_PERF: begin
                id.readperf = 1'b1;
                id.regdst   = 1'b1;
                id.regwrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ori takes its immediate zero-extended.
    assign id.signimm = (opcode == `OP_ORI) ? {{(`DATA_W-`IMM_W){1'b0}}, imm}
                                            : {{(`DATA_W-`IMM_W){imm[`IMM_W-1]}}, imm};

    // Free-running cycle counter.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    assign id.pcplus4   = pcplus4;
    assign id.srca      = rd1;
    assign id.writedata = rd2;
    assign id.srcc      = cycle_cnt;
    assign id.instr     = instr;

endmodule

// ==== design/id_ex.sv ====
`timescale 1ns/1ns

module id_ex import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  logic      flush,
    id_ex_if.consumer id,
    id_ex_if.producer ex
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex.readperf   <= 1'b0;
            ex.memtoreg   <= 1'b0;
            ex.memwrite   <= 1'b0;
            ex.alusrc     <= 1'b0;
            ex.regdst     <= 1'b0;
            ex.regwrite   <= 1'b0;
            ex.alucontrol <= ALU_AND;
            ex.pcplus4    <= '0;
            ex.srca       <= '0;
            ex.srcc       <= '0;
            ex.writedata  <= '0;
            ex.signimm    <= '0;
            ex.instr      <= '0;
        end else if (stall || flush) begin
            ex.readperf   <= 1'b0; // Bubble.
            ex.memtoreg   <= 1'b0;
            ex.memwrite   <= 1'b0;
            ex.alusrc     <= 1'b0;
            ex.regdst     <= 1'b0;
            ex.regwrite   <= 1'b0;
            ex.alucontrol <= ALU_AND;
            ex.pcplus4    <= '0;
            ex.srca       <= '0;
            ex.srcc       <= '0;
            ex.writedata  <= '0;
            ex.signimm    <= '0;
            ex.instr      <= '0;
        end else begin
            ex.readperf   <= id.readperf;
            ex.memtoreg   <= id.memtoreg;
            ex.memwrite   <= id.memwrite;
            ex.alusrc     <= id.alusrc;
            ex.regdst     <= id.regdst;
            ex.regwrite   <= id.regwrite;
            ex.alucontrol <= id.alucontrol;
            ex.pcplus4    <= id.pcplus4;
            ex.srca       <= id.srca;
            ex.srcc       <= id.srcc;
            ex.writedata  <= id.writedata;
            ex.signimm    <= id.signimm;
            ex.instr      <= id.instr;
        end
    end

    a_bubble: assert property (@(posedge clk) disable iff (reset)
        (stall || flush) |=> (!ex.regwrite && !ex.memwrite))
        else $error("bubble carried a write enable");

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import mips_pkg::*; (
    id_ex_if.consumer ex,
    output word_t     result,
    output word_t     writedata,
    output reg_addr_t writereg,
    output logic      regwrite,
    output logic      memtoreg,
    output logic      memwrite
);

    word_t srcb;
    word_t alu_out;
    logic  less;

    assign srcb = ex.alusrc ? ex.signimm : ex.writedata;
    assign less = $signed(ex.srca) < $signed(srcb); // Signed compare for slt.

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ex.alucontrol)
            ALU_AND: alu_out = ex.srca & srcb;
            ALU_OR:  alu_out = ex.srca | srcb;
            ALU_ADD: alu_out = ex.srca + srcb;
            ALU_SUB: alu_out = ex.srca - srcb;
            ALU_SLT: alu_out = {{($bits(word_t)-1){1'b0}}, less};
            default: alu_out = '0;
        endcase
    end

    // rdperf returns the cycle count.
    assign result = ex.readperf ? ex.srcc : alu_out;

    // rd for R-format, rt otherwise.
    assign writereg = ex.regdst ? ex.instr[15:11] : ex.instr[20:16];

    assign writedata = ex.writedata;
    assign regwrite  = ex.regwrite;
    assign memtoreg  = ex.memtoreg;
    assign memwrite  = ex.memwrite;

    a_alu_ctrl: assert property (@(posedge ex.clk)
        ex.alucontrol inside {ALU_AND, ALU_OR, ALU_ADD, ALU_SUB, ALU_SLT})
        else $error("undefined ALU control %0d", ex.alucontrol);

endmodule

// ==== design/decode_execute.sv ====
`timescale 1ns/1ns

module decode_execute import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  logic      flush,
    input  word_t     instr,
    input  word_t     pcplus4,
    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output word_t     result,
    output word_t     writedata,
    output reg_addr_t writereg,
    output logic      regwrite,
    output logic      memtoreg,
    output logic      memwrite
);

    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;

    id_ex_if id_bus (.clk(clk)); // Decode to ID/EX.
    id_ex_if ex_bus (.clk(clk)); // ID/EX to execute.

    regfile regfile0 (
        .clk   (clk),
        .reset (reset),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (wb_we),
        .wa    (wb_addr),
        .wd    (wb_data)
    );

    decode_stage decode0 (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .pcplus4 (pcplus4),
        .ra1     (ra1),
        .ra2     (ra2),
        .rd1     (rd1),
        .rd2     (rd2),
        .id      (id_bus)
    );

    id_ex id_ex0 (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .id    (id_bus),
        .ex    (ex_bus)
    );

    execute_stage execute0 (
        .ex        (ex_bus),
        .result    (result),
        .writedata (writedata),
        .writereg  (writereg),
        .regwrite  (regwrite),
        .memtoreg  (memtoreg),
        .memwrite  (memwrite)
    );

endmodule

// ==== tb/tb_decode_execute.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module tb_decode_execute import mips_pkg::*; ();

    localparam int TEST_N = 6;

    logic      clk;
    logic      reset;
    logic      stall;
    logic      flush;
    word_t     instr;
    word_t     pcplus4;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    word_t     result;
    word_t     writedata;
    reg_addr_t writereg;
    logic      regwrite;
    logic      memtoreg;
    logic      memwrite;

    word_t  model [0:`REG_N-1]; // Expected register contents.
    int     edges;              // Rising edges since reset fell.
    integer seed;

    decode_execute dut0 (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .instr     (instr),
        .pcplus4   (pcplus4),
        .wb_we     (wb_we),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .result    (result),
        .writedata (writedata),
        .writereg  (writereg),
        .regwrite  (regwrite),
        .memtoreg  (memtoreg),
        .memwrite  (memwrite)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TEST_N * 40 + 20) @(posedge clk);
        $display("Run timed out before all tests completed.");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "register number mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "control bit mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic word_t r_instr(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                      reg_addr_t rd, funct_t fn);
        return {op, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_instr(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // Reference ALU from the instruction set definitions.
    function automatic word_t alu_expect(funct_t fn, word_t a, word_t b);
        case (fn)
            `FN_ADD: return a + b;
            `FN_SUB: return a - b;
            `FN_AND: return a & b;
            `FN_OR:  return a | b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
        edges++;
    endtask

    task automatic write_reg(reg_addr_t addr, word_t data);
        wb_we   = 1'b1;
        wb_addr = addr;
        wb_data = data;
        step();
        wb_we = 1'b0;
        if (addr != '0) model[addr] = data;
    endtask

    // One instruction in, its EX outputs visible on return.
    task automatic issue(word_t ins);
        instr   = ins;
        pcplus4 = pcplus4 + 32'd4;
        step();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic regfile_readback();
        for (int i = 1; i <= 8; i++) write_reg(reg_addr_t'(i), $random(seed));
        write_reg('0, $random(seed)); // Must be ignored.
        for (int i = 1; i < 8; i += 2) begin
            issue(r_instr(`OP_RTYPE, reg_addr_t'(i), reg_addr_t'(i + 1), 5'd9, `FN_ADD));
            check_word("regfile add", model[i] + model[i + 1], result);
        end
        issue(r_instr(`OP_RTYPE, 5'd0, 5'd0, 5'd9, `FN_ADD));
        check_word("regfile zero", '0, result);
    endtask

    task automatic rtype_alu();
        funct_t fns [5] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};
        for (int k = 0; k < 5; k++) begin
            write_reg(5'd10, $random(seed));
            write_reg(5'd11, $random(seed));
            issue(r_instr(`OP_RTYPE, 5'd10, 5'd11, 5'd12, fns[k]));
            check_word("rtype result", alu_expect(fns[k], model[10], model[11]), result);
            check_reg("rtype writereg", 5'd12, writereg);
            check_bit("rtype regwrite", 1'b1, regwrite);
        end
    endtask

    task automatic imm_forms();
        imm_t  imm;
        word_t sext;
        imm  = imm_t'($random(seed)) | 16'h8000; // Negative, so sign and zero extension differ.
        sext = {{16{imm[15]}}, imm};
        issue(i_instr(`OP_ADDI, 5'd10, 5'd13, imm));
        check_word("addi result", model[10] + sext, result);
        check_reg("addi writereg", 5'd13, writereg);
        issue(i_instr(`OP_ORI, 5'd10, 5'd13, imm));
        check_word("ori result", model[10] | {16'd0, imm}, result);
        check_reg("ori writereg", 5'd13, writereg);
        issue(i_instr(`OP_LW, 5'd10, 5'd13, imm));
        check_word("lw address", model[10] + sext, result);
        check_bit("lw memtoreg", 1'b1, memtoreg);
        check_bit("lw regwrite", 1'b1, regwrite);
        issue(i_instr(`OP_SW, 5'd10, 5'd11, imm));
        check_word("sw address", model[10] + sext, result);
        check_bit("sw memwrite", 1'b1, memwrite);
        check_bit("sw regwrite", 1'b0, regwrite);
        check_word("sw writedata", model[11], writedata);
    endtask

    task automatic perf_counter();
        repeat (3) step();
        issue(r_instr(`OP_PERF, 5'd0, 5'd0, 5'd14, 6'd0));
        check_word("perf count", word_t'(edges - 1), result);
        check_reg("perf writereg", 5'd14, writereg);
        check_bit("perf regwrite", 1'b1, regwrite);
    endtask

    task automatic bubble_case(string name, logic use_flush);
        instr = r_instr(`OP_RTYPE, 5'd1, 5'd2, 5'd9, `FN_ADD);
        stall = ~use_flush;
        flush = use_flush;
        step();
        stall = 1'b0;
        flush = 1'b0;
        check_bit(name, 1'b0, regwrite);
        check_bit(name, 1'b0, memwrite);
        check_bit(name, 1'b0, memtoreg);
        check_word(name, '0, result);
        step(); // Same add presented again.
        check_word(name, model[1] + model[2], result);
        check_bit(name, 1'b1, regwrite);
    endtask

    task automatic bubble_insertion();
        bubble_case("stall bubble", 1'b0);
        bubble_case("flush bubble", 1'b1);
    endtask

    task automatic write_through();
        word_t v;
        v       = $random(seed);
        wb_we   = 1'b1;
        wb_addr = 5'd3;
        wb_data = v;
        issue(r_instr(`OP_RTYPE, 5'd3, 5'd4, 5'd15, `FN_ADD));
        wb_we    = 1'b0;
        model[3] = v;
        check_word("write-through", v + model[4], result);
    endtask

    initial begin
        reset   = 1'b1;
        stall   = 1'b0;
        flush   = 1'b0;
        instr   = '0;
        pcplus4 = '0;
        wb_we   = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        seed    = 32'h6489fe4f;
        for (int i = 0; i < `REG_N; i++) model[i] = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        edges = 0;
        check_bit("reset regwrite", 1'b0, regwrite);
        check_bit("reset memwrite", 1'b0, memwrite);
        check_bit("reset memtoreg", 1'b0, memtoreg);
        regfile_readback();
        rtype_alu();
        imm_forms();
        perf_counter();
        bubble_insertion();
        write_through();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/mips_pkg.sv
design/id_ex_if.sv
design/regfile.sv
design/decode_stage.sv
design/id_ex.sv
design/execute_stage.sv
design/decode_execute.sv
tb/tb_decode_execute.sv

// ==== Bender.yml ====
package:
  name: decode_execute

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mips_pkg.sv
      - design/id_ex_if.sv
      - design/regfile.sv
      - design/decode_stage.sv
      - design/id_ex.sv
      - design/execute_stage.sv
      - design/decode_execute.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/tb_decode_execute.sv
